//--- rtl/alu.sv
`timescale 1ns/10ps
module alu (
	alu_if.alu aif
);
	import cpu_pkg::*;

	logic [word_w-1:0]   shift_result;
	logic [2*word_w-1:0] mul_product;
	logic [word_w-1:0]   div_quotient;
	logic [word_w-1:0]   div_remainder;
	logic [word_w-1:0]   lo;  // Low half of c
	logic [word_w-1:0]   hi;  // High half, only mul and div fill it

	shift_unit u_shift (
		.a       (aif.a),
		.amount  (aif.b[4:0]),
		.op_code (aif.op_code),
		.result  (shift_result)
	);

	booth_mul u_mul (
		.a       (aif.a),
		.b       (aif.b),
		.product (mul_product)
	);

	div_unit u_div (
		.a         (aif.a),
		.b         (aif.b),
		.quotient  (div_quotient),
		.remainder (div_remainder)
	);

	always_comb begin
		lo = '0;
		hi = '0;
		case (aif.op_code)
			op_ld:  lo = aif.b;  // Pass B straight through
			op_add: lo = aif.a + aif.b;
			op_sub: lo = aif.a - aif.b;
			op_and: lo = aif.a & aif.b;
			op_or:  lo = aif.a | aif.b;
			op_neg: lo = -aif.a;
			op_not: lo = ~aif.a;
			op_shr, op_shra, op_shl, op_ror, op_rol: begin
				lo = shift_result;
			end
			op_mul: begin
				hi = mul_product[2*word_w-1:word_w];
				lo = mul_product[word_w-1:0];
			end
			op_div: begin
				hi = div_remainder;  // Remainder goes high, as HI expects
				lo = div_quotient;
			end
			default: begin
				// Reserved codes leave the result at zero
				lo = '0;
			end
		endcase
	end

	assign aif.c = {hi, lo};

endmodule

//--- rtl/alu_if.sv
`timescale 1ns/10ps
interface alu_if;
	import cpu_pkg::*;

	logic [word_w-1:0]   a;        // Operand A, from Y
	logic [word_w-1:0]   b;        // Operand B, from the bus
	op_code_e            op_code;
	logic [2*word_w-1:0] c;        // Full result, caught by Z

	modport datapath (
		output a, b, op_code,
		input  c
	);

	modport alu (
		input  a, b, op_code,
		output c
	);

endinterface

//--- rtl/booth_mul.sv
`timescale 1ns/10ps
module booth_mul (
	input  logic [cpu_pkg::word_w-1:0]   a,
	input  logic [cpu_pkg::word_w-1:0]   b,
	output logic [2*cpu_pkg::word_w-1:0] product
);
	import cpu_pkg::*;

	logic [word_w:0]     b_ext;    // B with the implicit zero below bit 0
	logic [2*word_w-1:0] a_wide;   // A sign-extended to the product width
	logic [2:0]          trip;     // Current Booth bit group
	logic [2*word_w-1:0] partial;
	logic [2*word_w-1:0] acc;

	assign b_ext  = {b, 1'b0};
	assign a_wide = {{word_w{a[word_w-1]}}, a};

	// Sixteen radix-4 digits, each one of 0, +-A, +-2A
	always_comb begin
		acc     = '0;
		trip    = '0;
		partial = '0;
		for (int i = 0; i < word_w / 2; i++) begin
			trip = b_ext[2*i +: 3];
			case (trip)
				3'b001, 3'b010: begin
					partial = a_wide;
				end
				3'b011: begin
					partial = a_wide << 1;
				end
				3'b100: begin
					partial = -(a_wide << 1);
				end
				3'b101, 3'b110: begin
					partial = -a_wide;
				end
				default: begin
					partial = '0;  // 000 and 111 add nothing
				end
			endcase
			acc = acc + (partial << (2 * i));
		end
	end

	assign product = acc;

endmodule

//--- rtl/cpu_pkg.sv
package cpu_pkg;

	localparam int word_w    = 32;                 // One data word
	localparam int reg_count = 16;                 // General registers
	localparam int reg_idx_w = $clog2(reg_count);  // 4 bits for r0..r15

	// Reference opcode values. ldi, st, addi, andi and ori stay reserved
	typedef enum logic [4:0] {
		op_ld   = 5'd0,
		op_ldi  = 5'd1,
		op_st   = 5'd2,
		op_add  = 5'd3,
		op_sub  = 5'd4,
		op_shr  = 5'd5,
		op_shra = 5'd6,
		op_shl  = 5'd7,
		op_ror  = 5'd8,
		op_rol  = 5'd9,
		op_and  = 5'd10,
		op_or   = 5'd11,
		op_addi = 5'd12,
		op_andi = 5'd13,
		op_ori  = 5'd14,
		op_mul  = 5'd15,
		op_div  = 5'd16,
		op_neg  = 5'd17,
		op_not  = 5'd18
	} op_code_e;

	// Who drives the shared bus this cycle
	typedef enum logic [2:0] {
		src_reg    = 3'd0,  // Register file at reg_sel
		src_hi     = 3'd1,
		src_lo     = 3'd2,
		src_zhi    = 3'd3,  // Upper half of Z
		src_zlo    = 3'd4,
		src_inport = 3'd5
	} bus_src_e;

endpackage

//--- rtl/datapath.sv
`timescale 1ns/10ps
module datapath (
	input  logic                          clk,
	input  logic                          rst_n,
	input  cpu_pkg::bus_src_e             bus_src,
	input  logic [cpu_pkg::reg_idx_w-1:0] reg_sel,
	input  logic                          rf_write,
	input  logic                          y_in,
	input  logic                          z_in,
	input  logic                          hi_in,
	input  logic                          lo_in,
	input  cpu_pkg::op_code_e             op_code,
	input  logic [cpu_pkg::word_w-1:0]    inport,
	output logic [cpu_pkg::word_w-1:0]    bus_out
);
	import cpu_pkg::*;

	logic [word_w-1:0]   y_q;   // ALU operand A
	logic [2*word_w-1:0] z_q;   // ALU result
	logic [word_w-1:0]   hi_q;
	logic [word_w-1:0]   lo_q;
	logic [word_w-1:0]   rf_q;

	alu_if alu_bus ();

	reg_file u_rf (
		.clk   (clk),
		.rst_n (rst_n),
		.write (rf_write),
		.sel   (reg_sel),
		.d     (bus_out),
		.q     (rf_q)
	);

	alu u_alu (
		.aif (alu_bus)
	);

	assign alu_bus.a       = y_q;
	assign alu_bus.b       = bus_out;  // B always rides the bus
	assign alu_bus.op_code = op_code;

	// Bus driver, combinational from the stored state
	always_comb begin
		case (bus_src)
			src_reg:    bus_out = rf_q;
			src_hi:     bus_out = hi_q;
			src_lo:     bus_out = lo_q;
			src_zhi:    bus_out = z_q[2*word_w-1:word_w];
			src_zlo:    bus_out = z_q[word_w-1:0];
			src_inport: bus_out = inport;
			default:    bus_out = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			y_q  <= '0;
			z_q  <= '0;
			hi_q <= '0;
			lo_q <= '0;
		end else begin
			// Strobes are independent and may all fire on one bus value
			if (y_in)
				y_q <= bus_out;
			if (z_in)
				z_q <= alu_bus.c;
			if (hi_in)
				hi_q <= bus_out;
			if (lo_in)
				lo_q <= bus_out;
		end
	end

endmodule

//--- rtl/div_unit.sv
`timescale 1ns/10ps
module div_unit (
	input  logic [cpu_pkg::word_w-1:0] a,
	input  logic [cpu_pkg::word_w-1:0] b,
	output logic [cpu_pkg::word_w-1:0] quotient,
	output logic [cpu_pkg::word_w-1:0] remainder
);
	import cpu_pkg::*;

	logic [word_w-1:0]          a_mag;
	logic [word_w-1:0]          b_mag;
	logic signed [word_w+1:0]   rem_acc;  // Two spare bits hold the sign of the partial remainder
	logic [word_w-1:0]          quo_acc;
	logic                       q_neg;

	assign a_mag = a[word_w-1] ? -a : a;  // Most negative value stays 2^31 unsigned
	assign b_mag = b[word_w-1] ? -b : b;
	assign q_neg = a[word_w-1] ^ b[word_w-1];

	always_comb begin
		rem_acc = '0;
		quo_acc = a_mag;
		for (int i = 0; i < word_w; i++) begin
			// Shift in the next dividend bit, then subtract or add back by sign
			if (!rem_acc[word_w+1])
				rem_acc = {rem_acc[word_w:0], quo_acc[word_w-1]} - {2'b00, b_mag};
			else
				rem_acc = {rem_acc[word_w:0], quo_acc[word_w-1]} + {2'b00, b_mag};
			quo_acc = {quo_acc[word_w-2:0], ~rem_acc[word_w+1]};
		end
		if (rem_acc[word_w+1])
			rem_acc = rem_acc + {2'b00, b_mag};  // Final correction
	end

	// Min value / -1 lands on quotient = a and remainder 0 from the sign step
	always_comb begin
		if (b == '0) begin
			quotient  = '1;
			remainder = a;
		end else begin
			quotient  = q_neg ? -quo_acc : quo_acc;
			remainder = a[word_w-1] ? -rem_acc[word_w-1:0] : rem_acc[word_w-1:0];
		end
	end

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/10ps
module reg_file (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          write,
	input  logic [cpu_pkg::reg_idx_w-1:0] sel,
	input  logic [cpu_pkg::word_w-1:0]    d,
	output logic [cpu_pkg::word_w-1:0]    q
);
	import cpu_pkg::*;

	logic [word_w-1:0] regs [reg_count];

	// Single bus machine, so one index serves both read and write
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (write) begin
			regs[sel] <= d;
		end
	end

	assign q = regs[sel];  // Old value until the edge

endmodule

//--- rtl/shift_unit.sv
`timescale 1ns/10ps
module shift_unit (
	input  logic [cpu_pkg::word_w-1:0] a,
	input  logic [4:0]                 amount,
	input  cpu_pkg::op_code_e          op_code,
	output logic [cpu_pkg::word_w-1:0] result
);
	import cpu_pkg::*;

	logic [2*word_w-1:0] doubled;
	logic [2*word_w-1:0] rot_right;
	logic [2*word_w-1:0] rot_left;

	// Rotates fall out of shifting two copies of A side by side
	assign doubled   = {a, a};
	assign rot_right = doubled >> amount;
	assign rot_left  = doubled << amount;

	always_comb begin
		case (op_code)
			op_shr: begin
				result = a >> amount;
			end
			op_shra: begin
				result = $signed(a) >>> amount;  // Sign bit fills from the left
			end
			op_shl: begin
				result = a << amount;
			end
			op_ror: begin
				result = rot_right[word_w-1:0];
			end
			op_rol: begin
				result = rot_left[2*word_w-1:word_w];
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

//--- run.sh
#!/bin/sh
verilator --binary --timing --timescale 1ns/10ps --top-module tb_datapath -f sources.f &&
	./obj_dir/Vtb_datapath | tee /dev/stderr | grep -qx 'TEST PASS' &&
	echo "Simulation passed" ||
	{ echo "Simulation failed"; exit 1; }

//--- sources.f
rtl/cpu_pkg.sv
rtl/alu_if.sv
rtl/shift_unit.sv
rtl/booth_mul.sv
rtl/div_unit.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/datapath.sv
test/dp_checker.sv
test/tb_datapath.sv

//--- test/dp_checker.sv
`timescale 1ns/10ps
module dp_checker (
	input  logic                          clk,
	input  logic                          rst_n,
	input  cpu_pkg::bus_src_e             bus_src,
	input  logic [cpu_pkg::reg_idx_w-1:0] reg_sel,
	input  logic                          rf_write,
	input  logic                          y_in,
	input  logic                          z_in,
	input  logic                          hi_in,
	input  logic                          lo_in,
	input  cpu_pkg::op_code_e             op_code,
	input  logic [cpu_pkg::word_w-1:0]    inport,
	input  logic [cpu_pkg::word_w-1:0]    bus_out,
	output int                            err_count,
	output int                            check_count
);
	import cpu_pkg::*;

	localparam logic [word_w-1:0] min_int = {1'b1, {(word_w-1){1'b0}}};

	logic [word_w-1:0]   m_regs [reg_count];
	logic [word_w-1:0]   m_y;
	logic [2*word_w-1:0] m_z;  // Full 64-bit result
	logic [word_w-1:0]   m_hi;
	logic [word_w-1:0]   m_lo;
	logic [word_w-1:0]   m_bus;

	// Result by the instruction set rules, high word first
	function automatic logic [2*word_w-1:0] alu_model(input logic [word_w-1:0] a,
			input logic [word_w-1:0] b, input op_code_e op);
		logic [word_w-1:0] zero;
		logic [4:0]        n;
		longint            sa;
		longint            sb;
		longint            q;
		longint            r;
		zero = '0;
		n    = b[4:0];
		sa   = longint'($signed(a));
		sb   = longint'($signed(b));
		case (op)
			op_ld:   return {zero, b};
			op_add:  return {zero, a + b};
			op_sub:  return {zero, a - b};
			op_and:  return {zero, a & b};
			op_or:   return {zero, a | b};
			op_neg:  return {zero, zero - a};
			op_not:  return {zero, ~a};
			op_shr:  return {zero, a >> n};
			op_shl:  return {zero, a << n};
			op_shra: return {zero, (a >> n) | (a[word_w-1] ? ~(~zero >> n) : zero)};
			op_ror:  return {zero, (a >> n) | (a << (word_w - n))};  // Shift by 32 gives 0
			op_rol:  return {zero, (a << n) | (a >> (word_w - n))};
			op_mul:  return sa * sb;
			op_div: begin
				if (b == zero)
					return {a, ~zero};
				if (a == min_int && b == ~zero)
					return {zero, a};  // The one overflow case
				q = sa / sb;  // Truncates toward zero
				r = sa % sb;  // Takes the sign of the dividend
				return {r[word_w-1:0], q[word_w-1:0]};
			end
			default: return '0;
		endcase
	endfunction

	always_comb begin
		case (bus_src)
			src_reg:    m_bus = m_regs[reg_sel];
			src_hi:     m_bus = m_hi;
			src_lo:     m_bus = m_lo;
			src_zhi:    m_bus = m_z[2*word_w-1:word_w];
			src_zlo:    m_bus = m_z[word_w-1:0];
			src_inport: m_bus = inport;
			default:    m_bus = '0;
		endcase
	end

	always @(posedge clk) begin : update
		logic [word_w-1:0] bus_now;
		bus_now = m_bus;
		if (!rst_n) begin
			for (int i = 0; i < reg_count; i++)
				m_regs[i] = '0;
			m_y  = '0;
			m_z  = '0;
			m_hi = '0;
			m_lo = '0;
		end else begin
			if (z_in)
				m_z = alu_model(m_y, bus_now, op_code);  // Y from before this edge
			if (y_in)
				m_y = bus_now;
			if (hi_in)
				m_hi = bus_now;
			if (lo_in)
				m_lo = bus_now;
			if (rf_write)
				m_regs[reg_sel] = bus_now;
		end
	end

	// Bus is settled half a cycle after the inputs change
	always @(negedge clk) begin
		if (rst_n) begin
			check_count++;
			if (bus_out !== m_bus) begin
				err_count++;
				$display("FAILED at %0d ns: bus_out expected %h, actual %h",
					$time, m_bus, bus_out);
			end
		end
	end

endmodule

//--- test/tb_datapath.sv
`timescale 1ns/10ps
module tb_datapath;
	import cpu_pkg::*;

	// Strobe bundle is {rf_write, y_in, z_in, hi_in, lo_in}
	localparam logic [4:0] wr_none = 5'b00000;
	localparam logic [4:0] wr_rf   = 5'b10000;
	localparam logic [4:0] wr_y    = 5'b01000;
	localparam logic [4:0] wr_z    = 5'b00100;
	localparam logic [4:0] wr_hi   = 5'b00010;
	localparam logic [4:0] wr_lo   = 5'b00001;
	localparam int rf_ops       = 64;
	localparam int alu_iters    = 200;
	localparam int shift_iters  = 160;
	localparam int muldiv_iters = 80;
	localparam int planned_cycles = 8 + 20 + 2 * rf_ops + 6 * 8 + 6
		+ 4 * (alu_iters + shift_iters + muldiv_iters + 10);  // Four cycles per ALU run
	localparam int cycle_limit = 2 * planned_cycles;

	logic                 clk;
	logic                 rst_n;
	bus_src_e             bus_src;
	logic [reg_idx_w-1:0] reg_sel;
	logic                 rf_write, y_in, z_in, hi_in, lo_in;
	op_code_e             op_code;
	logic [word_w-1:0]    inport;
	logic [word_w-1:0]    bus_out;
	int                   err_count;
	int                   check_count;
	int                   cycles;
	int                   tests_passed;
	int                   tests_failed;
	int                   errs_seen;
	int                   checks_seen;

	op_code_e basic_ops [8] = '{op_ld, op_add, op_sub, op_and, op_or, op_neg, op_not, op_ld};
	op_code_e reserved_ops [5] = '{op_ldi, op_st, op_addi, op_andi, op_ori};

	datapath dut0 (.*);
	dp_checker u_check (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic drive(input bus_src_e src, input logic [reg_idx_w-1:0] sel,
			input logic [4:0] strobes, input op_code_e op, input logic [word_w-1:0] data);
		@(posedge clk);
		#1;
		bus_src = src;
		reg_sel = sel;
		{rf_write, y_in, z_in, hi_in, lo_in} = strobes;
		op_code = op;
		inport  = data;
	endtask

	// Y takes A, Z catches the result with B on the bus, then both halves are read
	task automatic run_alu(input op_code_e op, input logic [word_w-1:0] a,
			input logic [word_w-1:0] b);
		drive(src_inport, '0, wr_y, op_ld, a);
		drive(src_inport, '0, wr_z, op, b);
		drive(src_zlo, '0, wr_none, op_ld, '0);
		drive(src_zhi, '0, wr_none, op_ld, '0);
	endtask

	task automatic end_test(input string name);
		@(negedge clk);
		#1;
		if (err_count == errs_seen && check_count > checks_seen) begin
			tests_passed++;
			$display("%s: passed, %0d bus checks", name, check_count - checks_seen);
		end else begin
			tests_failed++;
			$display("%s: failed, %0d bus mismatches", name, err_count - errs_seen);
		end
		errs_seen   = err_count;
		checks_seen = check_count;
	endtask

	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		int                target;
		logic [word_w-1:0] a;
		logic [word_w-1:0] v;
		logic [4:0]        amt;
		void'($urandom(13133));
		rst_n     = 1'b0;
		bus_src   = src_reg;
		reg_sel   = '0;
		{rf_write, y_in, z_in, hi_in, lo_in} = wr_none;
		op_code   = op_ld;
		inport    = '0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int i = 0; i < reg_count; i++)
			drive(src_reg, reg_idx_w'(i), wr_none, op_ld, '0);
		drive(src_hi, '0, wr_none, op_ld, '0);
		drive(src_lo, '0, wr_none, op_ld, '0);
		drive(src_zhi, '0, wr_none, op_ld, '0);
		drive(src_zlo, '0, wr_none, op_ld, '0);
		end_test("reset state");

		for (int i = 0; i < rf_ops; i++) begin
			target = $urandom_range(reg_count + 1);  // Top two stand for HI and LO
			if (target < reg_count)
				drive(src_inport, reg_idx_w'(target), wr_rf, op_ld, $urandom);
			else
				drive(src_inport, '0, (target == reg_count) ? wr_hi : wr_lo, op_ld, $urandom);
		end
		for (int i = 0; i < rf_ops; i++) begin
			target = $urandom_range(reg_count + 1);
			if (target < reg_count)
				drive(src_reg, reg_idx_w'(target), wr_none, op_ld, '0);
			else
				drive((target == reg_count) ? src_hi : src_lo, '0, wr_none, op_ld, '0);
		end
		end_test("register file and HI/LO");

		for (int i = 0; i < alu_iters; i++)
			run_alu(basic_ops[3'($urandom_range(7))], $urandom, $urandom);
		end_test("logic, add/sub, neg/not and ld");

		for (int i = 0; i < shift_iters; i++) begin
			if (i % 8 == 0)
				amt = 5'd0;
			else if (i % 8 == 1)
				amt = 5'd31;
			else
				amt = 5'($urandom_range(31));
			// Upper bits of B are noise the shifter must ignore
			run_alu(op_code_e'(5'(int'(op_shr) + i % 5)), $urandom, {27'($urandom), amt});
		end
		end_test("shifts and rotates");

		for (int i = 0; i < muldiv_iters; i++) begin
			a = $signed($urandom) >>> $urandom_range(31);  // Wide and narrow, both signs
			v = $signed($urandom) >>> $urandom_range(31);
			run_alu((i % 2 == 0) ? op_mul : op_div, a, v);
		end
		run_alu(op_div, $urandom, '0);
		run_alu(op_div, 32'h8000_0000, 32'hffff_ffff);
		run_alu(op_mul, 32'h8000_0000, 32'h8000_0000);
		run_alu(op_div, 32'hffff_fff9, 32'd2);
		run_alu(op_div, 32'd7, 32'hffff_fffe);
		end_test("multiply and divide");

		for (int k = 0; k < 5; k++)
			run_alu(reserved_ops[3'(k)], $urandom, $urandom);
		for (int i = 0; i < 8; i++) begin
			target = $urandom_range(reg_count - 1);
			v      = $urandom;
			drive(src_inport, reg_idx_w'(target), wr_rf | wr_y | wr_hi | wr_lo, op_ld, v);
			drive(src_reg, reg_idx_w'(target), wr_none, op_ld, '0);
			drive(src_hi, '0, wr_none, op_ld, '0);
			drive(src_lo, '0, wr_none, op_ld, '0);
			drive(src_inport, '0, wr_z, op_or, '0);  // Y or 0 copies Y into Z
			drive(src_zlo, '0, wr_none, op_ld, '0);
		end
		end_test("reserved opcodes and simultaneous strobes");

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && err_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
